//--- list.f
src/fifo_pkg.sv
src/fifo_push_ctrl_credit.sv
src/fifo_pop_ctrl.sv
src/fifo_ctrl_1r1w_push_credit.sv
src/fifo_ram_1r1w.sv
src/fifo_credit_top.sv
verification/fifo_credit_chk.sv
verification/fifo_credit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the credit FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module fifo_credit_tb -o fifo_credit_sim

# The log decides the result, so a failing run still reaches the search below
./obj_dir/fifo_credit_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- src/fifo_credit_top.sv
// Credit FIFO top level

`timescale 1ns/1ps
`default_nettype none

module fifo_credit_top (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              push_credit_stall,
  output logic                   push_credit,
  input  wire logic              push_valid,
  input  wire fifo_pkg::data_t   push_data,
  input  wire logic              pop_ready,
  output logic                   pop_valid,
  output fifo_pkg::data_t        pop_data,
  output logic                   full,
  output fifo_pkg::count_t       slots,
  output logic                   empty,
  output fifo_pkg::count_t       items,
  input  wire fifo_pkg::credit_t credit_initial,
  input  wire fifo_pkg::credit_t credit_withhold,
  output fifo_pkg::credit_t      credit_count,
  output fifo_pkg::credit_t      credit_available
);

  // RAM ports between controller and storage
  fifo_pkg::ram_wr_t      ram_wr;
  fifo_pkg::ram_rd_req_t  ram_rd_req;
  fifo_pkg::ram_rd_resp_t ram_rd_resp;

  fifo_ctrl_1r1w_push_credit u_ctrl (
    .clk (clk), .rst_n (rst_n),
    .push_credit_stall (push_credit_stall), .push_credit (push_credit),
    .push_valid (push_valid), .push_data (push_data),
    .pop_ready (pop_ready), .pop_valid (pop_valid), .pop_data (pop_data),
    .full (full), .slots (slots), .empty (empty), .items (items),
    .credit_initial (credit_initial), .credit_withhold (credit_withhold),
    .credit_count (credit_count), .credit_available (credit_available),
    .ram_wr (ram_wr), .ram_rd_req (ram_rd_req), .ram_rd_resp (ram_rd_resp)
  );

  // Storage sized to the FIFO depth
  fifo_ram_1r1w u_ram (
    .clk (clk), .ram_wr (ram_wr), .ram_rd_req (ram_rd_req), .ram_rd_resp (ram_rd_resp)
  );

endmodule

`default_nettype wire

//--- src/fifo_ctrl_1r1w_push_credit.sv
// FIFO controller, credit push and ready/valid pop

`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl_1r1w_push_credit (
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // Push side
  input  wire logic                   push_credit_stall,
  output logic                        push_credit,
  input  wire logic                   push_valid,
  input  wire fifo_pkg::data_t        push_data,

  // Pop side
  input  wire logic                   pop_ready,
  output logic                        pop_valid,
  output fifo_pkg::data_t             pop_data,

  // Status
  output logic                        full,
  output fifo_pkg::count_t            slots,
  output logic                        empty,
  output fifo_pkg::count_t            items,

  // Credit control and status
  input  wire fifo_pkg::credit_t      credit_initial,
  input  wire fifo_pkg::credit_t      credit_withhold,
  output fifo_pkg::credit_t           credit_count,
  output fifo_pkg::credit_t           credit_available,

  // External 1R1W RAM
  output fifo_pkg::ram_wr_t           ram_wr,
  output fifo_pkg::ram_rd_req_t       ram_rd_req,
  input  wire fifo_pkg::ram_rd_resp_t ram_rd_resp
);

  // Signals running between the two halves
  logic              bypass_ready;
  fifo_pkg::bypass_t bypass;
  logic              ram_push;
  logic              ram_pop;
  logic              bypass_pop;

  // Write pointer, free slots and credits
  fifo_push_ctrl_credit u_push_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .full              (full),
    .slots             (slots),
    .credit_initial    (credit_initial),
    .credit_withhold   (credit_withhold),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .bypass_ready      (bypass_ready),
    .bypass            (bypass),
    .ram_wr            (ram_wr),
    .ram_push          (ram_push),
    .ram_pop           (ram_pop),
    .bypass_pop        (bypass_pop)
  );

  // Read pointer, item count and the bypass path
  fifo_pop_ctrl u_pop_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .empty        (empty),
    .items        (items),
    .bypass_ready (bypass_ready),
    .bypass       (bypass),
    .bypass_pop   (bypass_pop),
    .ram_rd_req   (ram_rd_req),
    .ram_rd_resp  (ram_rd_resp),
    .ram_push     (ram_push),
    .ram_pop      (ram_pop)
  );

endmodule

`default_nettype wire

//--- src/fifo_pkg.sv
// FIFO shared definitions

`default_nettype none

package fifo_pkg;

  // ----------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------

  // Number of entries held in the external RAM
  localparam int DEPTH = 8;
  // Width of one FIFO entry
  localparam int DATA_WIDTH = 16;
  // The credit counter never needs to hold more than one credit per entry
  localparam int MAX_CREDIT = DEPTH;

  // Derived widths, counts run from 0 up to and including the maximum
  localparam int ADDR_WIDTH = $clog2(DEPTH);
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
  localparam int CREDIT_WIDTH = $clog2(MAX_CREDIT + 1);

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  // ----------------------------------------------------------
  // Port bundles
  // ----------------------------------------------------------

  // RAM write port, the entry lands in the array on the next edge
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } ram_wr_t;

  // RAM read address, answered in the same cycle
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ram_rd_req_t;

  // RAM read data, valid mirrors the request
  typedef struct packed {
    logic  valid;
    data_t data;
  } ram_rd_resp_t;

  // Incoming push offered to the pop side before it reaches the RAM
  typedef struct packed {
    logic  valid;
    data_t data;
  } bypass_t;

endpackage

`default_nettype wire

//--- src/fifo_pop_ctrl.sv
// FIFO pop control with bypass

`timescale 1ns/1ps
`default_nettype none

module fifo_pop_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // Pop side, ready and valid
  input  wire logic                  pop_ready,
  output logic                       pop_valid,
  output fifo_pkg::data_t            pop_data,

  // Pop side status
  output logic                       empty,
  output fifo_pkg::count_t           items,

  // Bypass handshake with push control
  output logic                       bypass_ready,
  input  wire fifo_pkg::bypass_t     bypass,
  output logic                       bypass_pop,

  // RAM read port and occupancy events
  output fifo_pkg::ram_rd_req_t      ram_rd_req,
  input  wire fifo_pkg::ram_rd_resp_t ram_rd_resp,
  input  wire logic                  ram_push,
  output logic                       ram_pop
);

  fifo_pkg::addr_t rd_ptr;

  // ----------------------------------------------------------
  // Read side of the RAM
  // ----------------------------------------------------------

  assign empty = (items == '0);

  // The head entry is read whenever the RAM holds anything
  always_comb begin
    ram_rd_req.valid = !empty;
    ram_rd_req.addr  = rd_ptr;
  end

  // ----------------------------------------------------------
  // Pop interface selection
  // ----------------------------------------------------------

  // The bypass is only taken when nothing older sits in the RAM
  assign bypass_ready = empty && pop_ready;

  // Valid does not look at ready, so the offer stays up under back-pressure
  // An untaken bypass entry goes to the RAM and shows the same data next cycle
  always_comb begin
    if (empty) begin
      pop_valid = bypass.valid;
      pop_data  = bypass.data;
    end else begin
      pop_valid = ram_rd_resp.valid;
      pop_data  = ram_rd_resp.data;
    end
  end

  // Each transfer is counted on exactly one of the two paths
  assign bypass_pop = bypass_ready && bypass.valid;
  assign ram_pop    = !empty && ram_rd_resp.valid && pop_ready;

  // ----------------------------------------------------------
  // Read pointer and item count
  // ----------------------------------------------------------

  // Read pointer wraps at the last entry, like the write pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (ram_pop) begin
      if (rd_ptr == fifo_pkg::addr_t'(fifo_pkg::DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Items count only what sits in the RAM, bypassed entries never show up here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      case ({ram_push, ram_pop})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/fifo_push_ctrl_credit.sv
// FIFO push control with credit return

`timescale 1ns/1ps
`default_nettype none

module fifo_push_ctrl_credit (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // Push side, credit and valid
  input  wire logic                 push_credit_stall,
  output logic                      push_credit,
  input  wire logic                 push_valid,
  input  wire fifo_pkg::data_t      push_data,

  // Push side status
  output logic                      full,
  output fifo_pkg::count_t          slots,

  // Credit control and status
  input  wire fifo_pkg::credit_t    credit_initial,
  input  wire fifo_pkg::credit_t    credit_withhold,
  output fifo_pkg::credit_t         credit_count,
  output fifo_pkg::credit_t         credit_available,

  // Bypass handshake with pop control
  input  wire logic                 bypass_ready,
  output fifo_pkg::bypass_t         bypass,

  // RAM write port and occupancy events
  output fifo_pkg::ram_wr_t         ram_wr,
  output logic                      ram_push,
  input  wire logic                 ram_pop,
  input  wire logic                 bypass_pop
);

  fifo_pkg::addr_t wr_ptr;
  logic            credit_en;
  logic            credit_return;

  // ----------------------------------------------------------
  // Bypass offer and RAM write
  // ----------------------------------------------------------

  // Every push is offered for bypass, pop control decides if it takes it
  always_comb begin
    bypass.valid = push_valid;
    bypass.data  = push_data;
  end

  // A push the pop side cannot take right now goes into the RAM
  assign ram_push = push_valid && !bypass_ready;

  always_comb begin
    ram_wr.valid = ram_push;
    ram_wr.addr  = wr_ptr;
    ram_wr.data  = push_data;
  end

  // Write pointer wraps at the last entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (ram_push) begin
      if (wr_ptr == fifo_pkg::addr_t'(fifo_pkg::DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Free slot tracking
  // ----------------------------------------------------------

  // Slots count free RAM entries, a push and a pop together cancel out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slots <= fifo_pkg::count_t'(fifo_pkg::DEPTH);
    end else begin
      case ({ram_push, ram_pop})
        2'b10:   slots <= slots - 1'b1;
        2'b01:   slots <= slots + 1'b1;
        default: slots <= slots;
      endcase
    end
  end

  assign full = (slots == '0);

  // ----------------------------------------------------------
  // Credit counter
  // ----------------------------------------------------------

  // Credits start flowing one cycle after reset is released
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_en <= 1'b0;
    end else begin
      credit_en <= 1'b1;
    end
  end

  // Any item that leaves, from the RAM or through the bypass, frees one slot
  assign credit_return = ram_pop || bypass_pop;

  // One credit goes back per cycle, only above the withheld floor and when not stalled
  assign push_credit = credit_en && !push_credit_stall && (credit_count > credit_withhold);

  // The counter takes its initial value from the live input during reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_count <= credit_initial;
    end else begin
      case ({credit_return, push_credit})
        2'b10:   credit_count <= credit_count + 1'b1;
        2'b01:   credit_count <= credit_count - 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

  // Credits that could be released now, never below zero
  assign credit_available = (credit_count > credit_withhold) ?
                            credit_count - credit_withhold : '0;

endmodule

`default_nettype wire

//--- src/fifo_ram_1r1w.sv
// Flop-based 1R1W RAM

`timescale 1ns/1ps
`default_nettype none

module fifo_ram_1r1w (
  input  wire logic                  clk,

  // Write port, one cycle latency
  input  wire fifo_pkg::ram_wr_t     ram_wr,

  // Read port, zero cycle latency
  input  wire fifo_pkg::ram_rd_req_t ram_rd_req,
  output fifo_pkg::ram_rd_resp_t     ram_rd_resp
);

  // Storage array, contents are undefined until first written
  fifo_pkg::data_t mem [fifo_pkg::DEPTH];

  // ----------------------------------------------------------
  // Write
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ----------------------------------------------------------
  // Read
  // ----------------------------------------------------------

  // A same-cycle write to the read address is not forwarded
  always_comb begin
    ram_rd_resp.valid = ram_rd_req.valid;
    ram_rd_resp.data  = mem[ram_rd_req.addr];
  end

endmodule

`default_nettype wire

//--- verification/fifo_credit_chk.sv
// FIFO protocol checker

`timescale 1ns/1ps
`default_nettype none

module fifo_credit_chk (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              push_credit_stall,
  input  wire logic              push_credit,
  input  wire logic              push_valid,
  input  wire logic              pop_ready,
  input  wire logic              pop_valid,
  input  wire fifo_pkg::data_t   pop_data,
  input  wire logic              full,
  input  wire fifo_pkg::count_t  items,
  input  wire fifo_pkg::credit_t credit_withhold,
  input  wire fifo_pkg::credit_t credit_count
);

  // Number of assertion failures, read by the testbench at the end of the run
  int fail_count = 0;

  // ----------------------------------------------------------
  // Credit side
  // ----------------------------------------------------------

  // A stall holds back every credit pulse
  credit_held_by_stall: assert property (@(posedge clk) disable iff (!rst_n)
    push_credit_stall |-> !push_credit)
    else begin
      $error("push_credit pulsed while push_credit_stall was high");
      fail_count++;
    end

  // Credits are only released above the withheld floor
  credit_above_floor: assert property (@(posedge clk) disable iff (!rst_n)
    push_credit |-> (credit_count > credit_withhold))
    else begin
      $error("push_credit pulsed with credit_count at or below credit_withhold");
      fail_count++;
    end

  // A sender that respects its credits never pushes into a full RAM
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    full |-> !push_valid)
    else begin
      $error("push_valid was high while full was high");
      fail_count++;
    end

  // ----------------------------------------------------------
  // Pop side and occupancy
  // ----------------------------------------------------------

  // An offered entry that is not taken keeps its data
  pop_data_held: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> $stable(pop_data))
    else begin
      $error("pop_data changed while pop_valid was high and pop_ready low");
      fail_count++;
    end

  items_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(items) <= fifo_pkg::DEPTH)
    else begin
      $error("items went above the FIFO depth");
      fail_count++;
    end

endmodule

// Attach the checker to every instance of the top level
bind fifo_credit_top fifo_credit_chk u_chk (
  .clk               (clk),
  .rst_n             (rst_n),
  .push_credit_stall (push_credit_stall),
  .push_credit       (push_credit),
  .push_valid        (push_valid),
  .pop_ready         (pop_ready),
  .pop_valid         (pop_valid),
  .pop_data          (pop_data),
  .full              (full),
  .items             (items),
  .credit_withhold   (credit_withhold),
  .credit_count      (credit_count)
);

`default_nettype wire

//--- verification/fifo_credit_tb.sv
// Credit FIFO testbench

`timescale 1ns/1ps
`default_nettype none

module fifo_credit_tb;

  localparam int CYCLE_LIMIT = 2000;

  logic              clk;
  logic              rst_n;
  logic              push_credit_stall;
  logic              push_credit;
  logic              push_valid;
  fifo_pkg::data_t   push_data;
  logic              pop_ready;
  logic              pop_valid;
  fifo_pkg::data_t   pop_data;
  logic              full;
  fifo_pkg::count_t  slots;
  logic              empty;
  fifo_pkg::count_t  items;
  fifo_pkg::credit_t credit_initial;
  fifo_pkg::credit_t credit_withhold;
  fifo_pkg::credit_t credit_count;
  fifo_pkg::credit_t credit_available;

  // Sender credits, scoreboard and run bookkeeping
  int              tb_credits;
  int              credit_pulses;
  int              pops;
  int              cycles;
  int              errors;
  int              tests_passed;
  int              tests_failed;
  int              errors_at_start;
  fifo_pkg::data_t sb[$];

  fifo_credit_top uut (.*);

  always #50 clk = ~clk;

  // ----------------------------------------------------------
  // Run limit
  // ----------------------------------------------------------

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Sender credits, scoreboard and conservation
  // ----------------------------------------------------------

  always @(posedge clk) begin : monitor
    fifo_pkg::data_t expected;
    if (!rst_n) begin
      tb_credits <= 0;
    end else begin
      // A push enters the queue before a same-cycle pop, which covers the bypass
      if (push_valid) begin
        sb.push_back(push_data);
      end
      if (pop_valid && pop_ready) begin
        pops <= pops + 1;
        if (sb.size() == 0) begin
          $display("Pop transfer at time %0t with no pushed item outstanding", $time);
          errors++;
        end else begin
          expected = sb.pop_front();
          assert (pop_data == expected) else begin
            $display("FAILED %0t pop_data expected %h got %h", $time, expected, pop_data);
            errors++;
          end
        end
      end
      // Every credit lives in the counter, in the RAM or with the sender
      assert (int'(credit_count) + int'(items) + tb_credits == int'(credit_initial)) else begin
        $display("FAILED %0t credit_count+items+tb_credits expected %0d got %0d", $time,
                 credit_initial, int'(credit_count) + int'(items) + tb_credits);
        errors++;
      end
      credit_pulses <= credit_pulses + int'(push_credit);
      tb_credits    <= tb_credits + int'(push_credit) - int'(push_valid);
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Drive one cycle of stimulus and push only while the sender holds credit
  task automatic drive_cycle(input logic want_push, input logic ready);
    @(posedge clk);
    #5;
    push_valid = want_push && (tb_credits > 0);
    push_data  = fifo_pkg::data_t'($urandom);
    pop_ready  = ready;
  endtask

  task automatic expect_value(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("FAILED %0t %s expected %0h got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Total errors from the testbench and the bound checker
  function automatic int error_total();
    return errors + uut.u_chk.fail_count;
  endfunction

  task automatic end_test(input string name);
    if (error_total() == errors_at_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed", name);
    end
    errors_at_start = error_total();
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------

  initial begin : tests
    fifo_pkg::data_t oldest;
    int              pushed;
    int              pops_before;
    clk = 1'b0;
    rst_n = 1'b0;
    push_credit_stall = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    credit_initial = fifo_pkg::credit_t'(fifo_pkg::DEPTH);
    credit_withhold = '0;
    tb_credits = 0;
    credit_pulses = 0;
    pops = 0;
    cycles = 0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    errors_at_start = 0;
    void'($urandom(32'h0839_3582));
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // The whole initial grant comes back one pulse at a time
    while (credit_count != 0) @(negedge clk);
    expect_value("credit pulses", int'(credit_initial), credit_pulses);
    expect_value("tb_credits", int'(credit_initial), tb_credits);
    end_test("1 initial credit grant");

    // Empty FIFO with a ready consumer passes the push straight through
    drive_cycle(1'b1, 1'b1);
    @(negedge clk);
    expect_value("pop_valid", 1, int'(pop_valid));
    expect_value("pop_data", int'(push_data), int'(pop_data));
    expect_value("items", 0, int'(items));
    drive_cycle(1'b0, 1'b1);
    @(negedge clk);
    expect_value("items", 0, int'(items));
    end_test("2 bypass cut-through");

    // Fill the RAM with the consumer stalled
    pushed = 0;
    pops_before = pops;
    while (pushed < fifo_pkg::DEPTH) begin
      drive_cycle(1'b1, 1'b0);
      if (push_valid) pushed++;
    end
    drive_cycle(1'b0, 1'b0);
    @(negedge clk);
    expect_value("full", 1, int'(full));
    expect_value("slots", 0, int'(slots));
    expect_value("items", fifo_pkg::DEPTH, int'(items));
    expect_value("tb_credits", 0, tb_credits);
    oldest = sb[0];
    repeat (3) begin
      expect_value("pop_valid", 1, int'(pop_valid));
      expect_value("pop_data", int'(oldest), int'(pop_data));
      drive_cycle(1'b0, 1'b0);
      @(negedge clk);
    end
    expect_value("pops", pops_before, pops);
    end_test("3 fill under back-pressure");

    // Drain in order, then let every freed credit return to the sender
    pops_before = pops;
    while (sb.size() > 0) drive_cycle(1'b0, 1'b1);
    @(negedge clk);
    expect_value("pops", pops_before + fifo_pkg::DEPTH, pops);
    expect_value("items", 0, int'(items));
    expect_value("empty", 1, int'(empty));
    while (credit_count != 0) @(negedge clk);
    expect_value("tb_credits", int'(credit_initial), tb_credits);
    end_test("4 ordered drain and credit return");

    // Bypassed items refill the counter up to the floor of 3
    @(posedge clk);
    #5;
    credit_withhold = fifo_pkg::credit_t'(3);
    repeat (5) drive_cycle(1'b1, 1'b1);
    repeat (4) drive_cycle(1'b0, 1'b1);
    @(negedge clk);
    expect_value("credit_count", 3, int'(credit_count));
    expect_value("credit_available", 0, int'(credit_available));
    expect_value("push_credit", 0, int'(push_credit));
    // With the floor gone, a stall alone keeps the credits in the counter
    @(posedge clk);
    #5;
    credit_withhold = '0;
    push_credit_stall = 1'b1;
    repeat (4) begin
      @(negedge clk);
      expect_value("push_credit", 0, int'(push_credit));
      expect_value("credit_count", 3, int'(credit_count));
      drive_cycle(1'b0, 1'b1);
    end
    push_credit_stall = 1'b0;
    while (credit_count != 0) @(negedge clk);
    end_test("5 withhold and stall");

    // Random pushes and back-pressure, then a full drain
    repeat (120) drive_cycle(logic'($urandom % 3 != 0), logic'($urandom % 4 != 0));
    // The last random push reaches the scoreboard only at the next edge
    drive_cycle(1'b0, 1'b1);
    while (sb.size() > 0) drive_cycle(1'b0, 1'b1);
    @(negedge clk);
    expect_value("items", 0, int'(items));
    end_test("6 random traffic");

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
